// File: alu.sv
`timescale 1ns/10ps

module alu (
    input  logic [proc_pkg::DATA_W-1:0]  i_a,
    input  logic [proc_pkg::DATA_W-1:0]  i_b,
    input  proc_pkg::alu_op_e            i_op,
    output logic [proc_pkg::DATA_W-1:0]  o_result,
    output logic                         o_zero,
    output logic                         o_neg,
    output logic                         o_carry
);

    logic [proc_pkg::DATA_W:0] sum_ext;

    // carry of a plus b for sco, independent of the selected op
    assign sum_ext = {1'b0, i_a} + {1'b0, i_b};
    assign o_carry = sum_ext[proc_pkg::DATA_W];

    always_comb begin
        case (i_op)
            proc_pkg::ALU_ADD:  o_result = sum_ext[proc_pkg::DATA_W-1:0];
            // register order of the isa: b minus a
            proc_pkg::ALU_SUB:  o_result = i_b - i_a;
            proc_pkg::ALU_XOR:  o_result = i_a ^ i_b;
            proc_pkg::ALU_ANDN: o_result = i_a & ~i_b;
            // low byte moves up, immediate fills the bottom
            proc_pkg::ALU_SLBI: o_result = {i_a[7:0], 8'h00} | i_b;
            default:            o_result = '0;
        endcase
    end

    //////////////////////////////
    // result flags
    //////////////////////////////
    assign o_zero = (o_result == '0);
    assign o_neg  = o_result[proc_pkg::DATA_W-1];

endmodule

// File: build.f
proc_pkg.sv
memory2c.sv
rf.sv
alu.sv
control.sv
proc.sv
tb_proc.sv

// File: control.sv
`timescale 1ns/10ps

module control (
    input  logic [4:0]           i_opcode,
    input  logic [1:0]           i_func,
    output proc_pkg::alu_op_e    o_alu_op,
    output logic                 o_b_imm,
    output proc_pkg::imm_sel_e   o_imm_sel,
    output proc_pkg::wb_sel_e    o_wb_sel,
    output logic [1:0]           o_dst_sel,
    output logic                 o_reg_we,
    output logic                 o_mem_we,
    output logic                 o_branch,
    output logic                 o_jump,
    output logic                 o_jr,
    output logic                 o_halt,
    output logic                 o_illegal
);

    proc_pkg::opcode_e op;

    assign op = proc_pkg::opcode_e'(i_opcode);

    always_comb begin
        // defaults describe a plain i-format alu op with no side effects
        o_alu_op  = proc_pkg::ALU_ADD;
        o_b_imm   = 1'b1;
        o_imm_sel = proc_pkg::IMM5S;
        o_wb_sel  = proc_pkg::WB_ALU;
        o_dst_sel = proc_pkg::DST_RDI;
        o_reg_we  = 1'b0;
        o_mem_we  = 1'b0;
        o_branch  = 1'b0;
        o_jump    = 1'b0;
        o_jr      = 1'b0;
        o_halt    = 1'b0;
        o_illegal = 1'b0;

        case (op)
            proc_pkg::OP_HALT: o_halt = 1'b1;
            proc_pkg::OP_NOP: begin
            end

            //////////////////////////////
            // jumps
            //////////////////////////////
            proc_pkg::OP_J: o_jump = 1'b1;
            proc_pkg::OP_JAL: begin
                o_jump    = 1'b1;
                o_reg_we  = 1'b1;
                o_wb_sel  = proc_pkg::WB_LINK;
                o_dst_sel = proc_pkg::DST_R7;
            end
            // target is rs plus imm8 through the alu
            proc_pkg::OP_JR: begin
                o_jr      = 1'b1;
                o_imm_sel = proc_pkg::IMM8S;
            end

            //////////////////////////////
            // i-format alu
            //////////////////////////////
            proc_pkg::OP_ADDI: o_reg_we = 1'b1;
            proc_pkg::OP_SUBI: begin
                o_reg_we = 1'b1;
                o_alu_op = proc_pkg::ALU_SUB;
            end
            proc_pkg::OP_XORI: begin
                o_reg_we  = 1'b1;
                o_alu_op  = proc_pkg::ALU_XOR;
                o_imm_sel = proc_pkg::IMM5Z;
            end
            proc_pkg::OP_ANDNI: begin
                o_reg_we  = 1'b1;
                o_alu_op  = proc_pkg::ALU_ANDN;
                o_imm_sel = proc_pkg::IMM5Z;
            end

            // condition rides in opcode bits 1:0
            proc_pkg::OP_BEQZ, proc_pkg::OP_BNEZ,
            proc_pkg::OP_BLTZ, proc_pkg::OP_BGEZ: begin
                o_branch  = 1'b1;
                o_imm_sel = proc_pkg::IMM8S;
            end

            //////////////////////////////
            // memory and byte loads
            //////////////////////////////
            proc_pkg::OP_ST: o_mem_we = 1'b1;
            proc_pkg::OP_LD: begin
                o_reg_we = 1'b1;
                o_wb_sel = proc_pkg::WB_MEM;
            end
            proc_pkg::OP_SLBI: begin
                o_reg_we  = 1'b1;
                o_alu_op  = proc_pkg::ALU_SLBI;
                o_imm_sel = proc_pkg::IMM8Z;
                o_dst_sel = proc_pkg::DST_RS;
            end
            // proc zeroes operand a, so this is 0 + imm8
            proc_pkg::OP_LBI: begin
                o_reg_we  = 1'b1;
                o_imm_sel = proc_pkg::IMM8S;
                o_dst_sel = proc_pkg::DST_RS;
            end

            //////////////////////////////
            // r-format
            //////////////////////////////
            proc_pkg::OP_RALU: begin
                o_reg_we  = 1'b1;
                o_b_imm   = 1'b0;
                o_dst_sel = proc_pkg::DST_RDR;
                case (i_func)
                    2'b00:   o_alu_op = proc_pkg::ALU_ADD;
                    2'b01:   o_alu_op = proc_pkg::ALU_SUB;
                    2'b10:   o_alu_op = proc_pkg::ALU_XOR;
                    default: o_alu_op = proc_pkg::ALU_ANDN;
                endcase
            end
            proc_pkg::OP_SEQ, proc_pkg::OP_SLT,
            proc_pkg::OP_SLE, proc_pkg::OP_SCO: begin
                o_reg_we  = 1'b1;
                o_b_imm   = 1'b0;
                o_dst_sel = proc_pkg::DST_RDR;
                o_alu_op  = proc_pkg::ALU_SUB;
                o_wb_sel  = proc_pkg::WB_SET;
            end

            default: o_illegal = 1'b1;
        endcase
    end

endmodule

// File: memory2c.sv
`timescale 1ns/10ps

module memory2c (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_we,
    input  logic [proc_pkg::MEM_AW-1:0]   i_addr,
    input  logic [proc_pkg::DATA_W-1:0]   i_wdata,
    output logic [proc_pkg::DATA_W-1:0]   o_rdata
);

    logic [proc_pkg::DATA_W-1:0] mem [proc_pkg::MEM_WORDS];

    //////////////////////////////
    // write port
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < proc_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // read is combinational, no bypass of a same-edge write
    assign o_rdata = mem[i_addr];

endmodule

// File: proc.sv
`timescale 1ns/10ps

module proc (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_start,
    input  logic                          i_load_we,
    input  logic                          i_load_dmem,
    input  logic [proc_pkg::MEM_AW-1:0]   i_load_addr,
    input  logic [proc_pkg::DATA_W-1:0]   i_load_data,
    output logic                          o_st_valid,
    output logic [proc_pkg::DATA_W-1:0]   o_st_addr,
    output logic [proc_pkg::DATA_W-1:0]   o_st_data,
    output logic                          o_halted,
    output logic                          o_err
);

    localparam int W = proc_pkg::DATA_W;

    proc_pkg::core_state_e state;
    logic [W-1:0] pc;
    logic [W-1:0] pc_plus2;
    logic [W-1:0] next_pc;
    logic [W-1:0] instr;
    logic         idle;
    logic         running;

    // decode
    proc_pkg::alu_op_e  alu_op;
    proc_pkg::imm_sel_e imm_sel;
    proc_pkg::wb_sel_e  wb_sel;
    logic [1:0]         dst_sel;
    logic b_imm, reg_we, mem_we, branch, jump, jr, halt, illegal;

    // datapath
    logic [W-1:0] imm_ext;
    logic [W-1:0] jdisp_ext;
    logic [W-1:0] rd1_data, rd2_data;
    logic [W-1:0] alu_a, alu_b, alu_result;
    logic         alu_zero, alu_neg, alu_carry;
    logic         set_bit;
    logic         br_taken;
    logic [W-1:0] wb_data;
    logic [proc_pkg::REG_AW-1:0] wr_sel;

    // memory ports
    logic                      imem_we, dmem_we;
    logic [proc_pkg::MEM_AW-1:0] imem_addr, dmem_addr;
    logic [W-1:0]              dmem_wdata, dmem_rdata;

    assign idle    = (state == proc_pkg::ST_IDLE);
    assign running = (state == proc_pkg::ST_RUN);

    //////////////////////////////
    // core state and pc
    //////////////////////////////
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= proc_pkg::ST_IDLE;
            pc    <= '0;
            o_err <= 1'b0;
        end else begin
            case (state)
                proc_pkg::ST_IDLE: begin
                    if (i_start) begin
                        state <= proc_pkg::ST_RUN;
                        pc    <= '0;
                    end
                end
                proc_pkg::ST_RUN: begin
                    if (halt || illegal) begin
                        state <= proc_pkg::ST_HALTED;
                        // sticky until reset, halted is never left
                        if (illegal) begin
                            o_err <= 1'b1;
                        end
                    end else begin
                        pc <= next_pc;
                    end
                end
                proc_pkg::ST_HALTED: begin
                end
                default: state <= proc_pkg::ST_IDLE;
            endcase
        end
    end

    assign o_halted = (state == proc_pkg::ST_HALTED);
    assign pc_plus2 = pc + W'(2);

    //////////////////////////////
    // fetch and decode
    //////////////////////////////
    // loader owns the memory addresses while idle
    assign imem_we   = idle & i_load_we & ~i_load_dmem;
    assign imem_addr = idle ? i_load_addr : pc[proc_pkg::MEM_AW:1];

    memory2c imem (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_we     (imem_we),
        .i_addr   (imem_addr),
        .i_wdata  (i_load_data),
        .o_rdata  (instr)
    );

    control ctrl (
        .i_opcode  (instr[15:11]),
        .i_func    (instr[1:0]),
        .o_alu_op  (alu_op),
        .o_b_imm   (b_imm),
        .o_imm_sel (imm_sel),
        .o_wb_sel  (wb_sel),
        .o_dst_sel (dst_sel),
        .o_reg_we  (reg_we),
        .o_mem_we  (mem_we),
        .o_branch  (branch),
        .o_jump    (jump),
        .o_jr      (jr),
        .o_halt    (halt),
        .o_illegal (illegal)
    );

    always_comb begin
        case (imm_sel)
            proc_pkg::IMM5S: imm_ext = {{(W-5){instr[4]}}, instr[4:0]};
            proc_pkg::IMM5Z: imm_ext = {{(W-5){1'b0}}, instr[4:0]};
            proc_pkg::IMM8S: imm_ext = {{(W-8){instr[7]}}, instr[7:0]};
            default:         imm_ext = {{(W-8){1'b0}}, instr[7:0]};
        endcase
    end

    assign jdisp_ext = {{(W-11){instr[10]}}, instr[10:0]};

    //////////////////////////////
    // registers and alu
    //////////////////////////////
    always_comb begin
        case (dst_sel)
            proc_pkg::DST_RS:  wr_sel = instr[10:8];
            proc_pkg::DST_RDI: wr_sel = instr[7:5];
            proc_pkg::DST_RDR: wr_sel = instr[4:2];
            default:           wr_sel = 3'd7;
        endcase
    end

    rf regs (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rd1_sel  (instr[10:8]),
        .i_rd2_sel  (instr[7:5]),
        .i_wr_sel   (wr_sel),
        .i_wr_data  (wb_data),
        .i_we       (reg_we & running),
        .o_rd1_data (rd1_data),
        .o_rd2_data (rd2_data)
    );

    // lbi is an add with operand a forced to zero
    assign alu_a = (instr[15:11] == proc_pkg::OP_LBI) ? '0 : rd1_data;
    assign alu_b = b_imm ? imm_ext : rd2_data;

    alu alu_i (
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_op     (alu_op),
        .o_result (alu_result),
        .o_zero   (alu_zero),
        .o_neg    (alu_neg),
        .o_carry  (alu_carry)
    );

    // compare kind in opcode bits 1:0: seq, slt, sle, sco
    always_comb begin
        case (instr[12:11])
            2'b00:   set_bit = alu_zero;
            2'b01:   set_bit = alu_neg;
            2'b10:   set_bit = alu_neg | alu_zero;
            default: set_bit = alu_carry;
        endcase
    end

    always_comb begin
        case (wb_sel)
            proc_pkg::WB_ALU:  wb_data = alu_result;
            proc_pkg::WB_MEM:  wb_data = dmem_rdata;
            proc_pkg::WB_LINK: wb_data = pc_plus2;
            default:           wb_data = {{(W-1){1'b0}}, set_bit};
        endcase
    end

    //////////////////////////////
    // data memory and store port
    //////////////////////////////
    assign o_st_valid = mem_we & running;
    assign o_st_addr  = alu_result;
    assign o_st_data  = rd2_data;

    assign dmem_we    = (idle & i_load_we & i_load_dmem) | o_st_valid;
    assign dmem_addr  = idle ? i_load_addr : alu_result[proc_pkg::MEM_AW:1];
    assign dmem_wdata = idle ? i_load_data : rd2_data;

    memory2c dmem (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_we     (dmem_we),
        .i_addr   (dmem_addr),
        .i_wdata  (dmem_wdata),
        .o_rdata  (dmem_rdata)
    );

    //////////////////////////////
    // next pc
    //////////////////////////////
    // branch tests rs itself, not the alu result
    always_comb begin
        case (instr[12:11])
            2'b00:   br_taken = (rd1_data == '0);
            2'b01:   br_taken = (rd1_data != '0);
            2'b10:   br_taken = rd1_data[W-1];
            default: br_taken = ~rd1_data[W-1];
        endcase
    end

    always_comb begin
        if (jr) begin
            next_pc = alu_result;
        end else if (jump) begin
            next_pc = pc_plus2 + jdisp_ext;
        end else if (branch && br_taken) begin
            next_pc = pc_plus2 + imm_ext;
        end else begin
            next_pc = pc_plus2;
        end
    end

endmodule

// File: proc_pkg.sv
package proc_pkg;

    //////////////////////////////
    // widths and depths
    //////////////////////////////
    localparam int DATA_W    = 16;
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);
    localparam int REG_N     = 8;
    localparam int REG_AW    = $clog2(REG_N);

    // destination register select
    localparam logic [1:0] DST_RS  = 2'd0;
    localparam logic [1:0] DST_RDI = 2'd1;
    localparam logic [1:0] DST_RDR = 2'd2;
    localparam logic [1:0] DST_R7  = 2'd3;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // instruction bits 15:11
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b11000,
        OP_RALU  = 5'b11011,
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_e;

    // sub is b minus a, andn is a and not b
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_ANDN,
        ALU_SLBI
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HALTED
    } core_state_e;

    typedef enum logic [1:0] {
        IMM5S,
        IMM5Z,
        IMM8S,
        IMM8Z
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK,
        WB_SET
    } wb_sel_e;

endpackage

// File: rf.sv
`timescale 1ns/10ps

module rf (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic [proc_pkg::REG_AW-1:0]   i_rd1_sel,
    input  logic [proc_pkg::REG_AW-1:0]   i_rd2_sel,
    input  logic [proc_pkg::REG_AW-1:0]   i_wr_sel,
    input  logic [proc_pkg::DATA_W-1:0]   i_wr_data,
    input  logic                          i_we,
    output logic [proc_pkg::DATA_W-1:0]   o_rd1_data,
    output logic [proc_pkg::DATA_W-1:0]   o_rd2_data
);

    logic [proc_pkg::DATA_W-1:0] regs [proc_pkg::REG_N];

    // one write per cycle
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < proc_pkg::REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wr_sel] <= i_wr_data;
        end
    end

    // two independent read ports
    assign o_rd1_data = regs[i_rd1_sel];
    assign o_rd2_data = regs[i_rd2_sel];

endmodule

// File: tb_proc.sv
`timescale 1ns/10ps

module tb_proc;

    localparam int RESET_CYCLES = 10;
    localparam int RUN_BUDGET   = 80;
    // 6 tests x (loader writes + 80 run cycles) plus resets, rounded up
    localparam int CYCLE_LIMIT  = 2500;

    logic        i_clk = 1'b0;
    logic        i_arst_n;
    logic        i_start;
    logic        i_load_we;
    logic        i_load_dmem;
    logic [7:0]  i_load_addr;
    logic [15:0] i_load_data;
    logic        o_st_valid;
    logic [15:0] o_st_addr;
    logic [15:0] o_st_data;
    logic        o_halted;
    logic        o_err;

    logic [15:0] prog [$];
    logic [7:0]  pre_idx [$];
    logic [15:0] pre_data [$];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic [15:0] want_addr;
    logic [15:0] want_data;
    logic [15:0] base_addr;
    int          nstores;
    bit          started;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          e0;

    proc proc_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_start     (i_start),
        .i_load_we   (i_load_we),
        .i_load_dmem (i_load_dmem),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_st_valid  (o_st_valid),
        .o_st_addr   (o_st_addr),
        .o_st_data   (o_st_data),
        .o_halted    (o_halted),
        .o_err       (o_err)
    );

    always #10 i_clk = ~i_clk;

    //////////////////////////////
    // instruction encoding
    //////////////////////////////
    function automatic logic [15:0] imm5_instr(proc_pkg::opcode_e op, int rs, int rd, int imm);
        return {op, 3'(rs), 3'(rd), 5'(imm)};
    endfunction

    function automatic logic [15:0] reg_instr(proc_pkg::opcode_e op, int rs, int rt, int rd,
                                              int func);
        return {op, 3'(rs), 3'(rt), 3'(rd), 2'(func)};
    endfunction

    function automatic logic [15:0] imm8_instr(proc_pkg::opcode_e op, int rs, int imm);
        return {op, 3'(rs), 8'(imm)};
    endfunction

    function automatic logic [15:0] jump_instr(proc_pkg::opcode_e op, int disp);
        return {op, 11'(disp)};
    endfunction

    function automatic logic [15:0] sext5(input logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    function automatic logic [15:0] rand16();
        return 16'($urandom());
    endfunction

    //////////////////////////////
    // program building
    //////////////////////////////
    // every program starts by pointing r6 at the store area
    task automatic new_program(input logic [15:0] base);
        prog.delete();
        pre_idx.delete();
        pre_data.delete();
        exp_addr.delete();
        exp_data.delete();
        nstores   = 0;
        base_addr = base;
        prog.push_back(imm8_instr(proc_pkg::OP_LBI, 6, base[7:0]));
    endtask

    task automatic load_const(input int rs, input logic [15:0] value);
        prog.push_back(imm8_instr(proc_pkg::OP_LBI, rs, value[15:8]));
        prog.push_back(imm8_instr(proc_pkg::OP_SLBI, rs, value[7:0]));
    endtask

    task automatic expect_store(input logic [15:0] addr, input logic [15:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // instr leaves its result in r3, which then goes out through st
    task automatic op_and_store(input logic [15:0] instr, input logic [15:0] result);
        int off;
        off = 2 * (nstores % 8);
        prog.push_back(instr);
        prog.push_back(imm5_instr(proc_pkg::OP_ST, 6, 3, off));
        expect_store(base_addr + sext5(5'(off)), result);
        nstores++;
    endtask

    task automatic preload_word(input logic [7:0] idx, input logic [15:0] data);
        pre_idx.push_back(idx);
        pre_data.push_back(data);
    endtask

    //////////////////////////////
    // pin level tasks
    //////////////////////////////
    task automatic apply_reset();
        @(posedge i_clk);
        i_arst_n <= 1'b0;
        started = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_arst_n <= 1'b1;
    endtask

    task automatic loader_write(input logic dmem, input int idx, input logic [15:0] data);
        @(posedge i_clk);
        i_load_we   <= 1'b1;
        i_load_dmem <= dmem;
        i_load_addr <= 8'(idx);
        i_load_data <= data;
        @(posedge i_clk);
        i_load_we   <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge i_clk);
        i_start <= 1'b1;
        started = 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
    endtask

    task automatic run_program(input logic exp_err);
        int n;
        prog.push_back(jump_instr(proc_pkg::OP_HALT, 0));
        apply_reset();
        for (int i = 0; i < prog.size(); i++) begin
            loader_write(1'b0, i, prog[i]);
        end
        for (int i = 0; i < pre_idx.size(); i++) begin
            loader_write(1'b1, pre_idx[i], pre_data[i]);
        end
        pulse_start();
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_halted && n < RUN_BUDGET);
        assert (o_halted) else begin
            $display("core did not halt within %0d cycles", RUN_BUDGET);
            errors++;
        end
        assert (o_err == exp_err) else begin
            $display("MISMATCH o_err: got %h expected %h", o_err, exp_err);
            errors++;
        end
        assert (exp_addr.size() == 0) else begin
            $display("%0d expected stores never appeared", exp_addr.size());
            errors++;
        end
    endtask

    task automatic report(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-10s pass", name);
        end else begin
            tests_failed++;
            $display("test %-10s fail (%0d errors)", name, errors - errors_before);
        end
    endtask

    //////////////////////////////
    // store port monitor
    //////////////////////////////
    always @(negedge i_clk) begin
        if (i_arst_n) begin
            assert (!o_st_valid || (started && !o_halted)) else begin
                $display("store strobe seen while the core was not running");
                errors++;
            end
            if (o_st_valid) begin
                assert (exp_addr.size() != 0) else begin
                    $display("unexpected store to address %h", o_st_addr);
                    errors++;
                end
                if (exp_addr.size() != 0) begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    assert (o_st_addr == want_addr) else begin
                        $display("MISMATCH o_st_addr: got %h expected %h", o_st_addr, want_addr);
                        errors++;
                    end
                    assert (o_st_data == want_data) else begin
                        $display("MISMATCH o_st_data: got %h expected %h", o_st_data, want_data);
                        errors++;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // tests
    //////////////////////////////
    task automatic arith_test();
        logic [15:0] a;
        logic [15:0] b;
        logic [4:0]  imm;
        a   = rand16();
        b   = rand16();
        imm = 5'($urandom());
        new_program(16'h0040);
        load_const(1, a);
        load_const(2, b);
        op_and_store(imm5_instr(proc_pkg::OP_ADDI, 1, 3, 0), a);
        op_and_store(imm5_instr(proc_pkg::OP_ADDI, 1, 3, imm), a + sext5(imm));
        op_and_store(imm5_instr(proc_pkg::OP_SUBI, 1, 3, imm), sext5(imm) - a);
        op_and_store(imm5_instr(proc_pkg::OP_XORI, 1, 3, imm), a ^ {11'd0, imm});
        op_and_store(imm5_instr(proc_pkg::OP_ANDNI, 1, 3, imm), a & ~{11'd0, imm});
        op_and_store(reg_instr(proc_pkg::OP_RALU, 1, 2, 3, 0), a + b);
        op_and_store(reg_instr(proc_pkg::OP_RALU, 1, 2, 3, 1), b - a);
        op_and_store(reg_instr(proc_pkg::OP_RALU, 1, 2, 3, 2), a ^ b);
        op_and_store(reg_instr(proc_pkg::OP_RALU, 1, 2, 3, 3), a & ~b);
        run_program(1'b0);
    endtask

    // compares look at rt minus rs, sco at the carry of rs plus rt
    task automatic compare_test();
        logic [15:0] x [3];
        logic [15:0] y [3];
        logic [15:0] d;
        logic [16:0] s;
        x[0] = rand16();
        y[0] = rand16();
        x[1] = rand16();
        y[1] = x[1];
        x[2] = 16'hffff;
        y[2] = 16'h0001;
        new_program(16'h0040);
        for (int p = 0; p < 3; p++) begin
            load_const(1, x[p]);
            load_const(2, y[p]);
            d = y[p] - x[p];
            s = {1'b0, x[p]} + {1'b0, y[p]};
            op_and_store(reg_instr(proc_pkg::OP_SEQ, 1, 2, 3, 0), {15'd0, d == 16'd0});
            op_and_store(reg_instr(proc_pkg::OP_SLT, 1, 2, 3, 0), {15'd0, d[15]});
            op_and_store(reg_instr(proc_pkg::OP_SLE, 1, 2, 3, 0),
                         {15'd0, d[15] | (d == 16'd0)});
            op_and_store(reg_instr(proc_pkg::OP_SCO, 1, 2, 3, 0), {15'd0, s[16]});
        end
        run_program(1'b0);
    endtask

    task automatic load_store_test();
        logic [15:0] w;
        int          off;
        new_program(16'h0048);
        for (int k = 0; k < 4; k++) begin
            w   = rand16();
            off = -8 + 2 * k;
            preload_word(8'((base_addr + sext5(5'(off))) >> 1), w);
            prog.push_back(imm5_instr(proc_pkg::OP_LD, 6, 3, off));
            op_and_store(imm5_instr(proc_pkg::OP_ADDI, 3, 3, 1), w + 16'd1);
        end
        run_program(1'b0);
    endtask

    // r1 zero, r2 negative, r4 positive; each case stores its own marker
    task automatic branch_test();
        proc_pkg::opcode_e br_op [9] = '{
            proc_pkg::OP_BEQZ, proc_pkg::OP_BEQZ, proc_pkg::OP_BNEZ,
            proc_pkg::OP_BNEZ, proc_pkg::OP_BLTZ, proc_pkg::OP_BLTZ,
            proc_pkg::OP_BGEZ, proc_pkg::OP_BGEZ, proc_pkg::OP_BGEZ};
        int          br_rs [9] = '{1, 4, 2, 1, 2, 4, 4, 1, 2};
        logic [15:0] v [8];
        logic        taken;
        v[1] = 16'h0000;
        v[2] = rand16() | 16'h8000;
        v[4] = (rand16() >> 1) | 16'h0001;
        new_program(16'h0040);
        load_const(1, v[1]);
        load_const(2, v[2]);
        load_const(4, v[4]);
        for (int k = 0; k < 9; k++) begin
            case (br_op[k])
                proc_pkg::OP_BEQZ: taken = (v[br_rs[k]] == 16'd0);
                proc_pkg::OP_BNEZ: taken = (v[br_rs[k]] != 16'd0);
                proc_pkg::OP_BLTZ: taken = v[br_rs[k]][15];
                default:           taken = !v[br_rs[k]][15];
            endcase
            prog.push_back(imm8_instr(proc_pkg::OP_LBI, 3, 'h10 + k));
            // taken skips the not-taken marker
            prog.push_back(imm8_instr(br_op[k], br_rs[k], 2));
            op_and_store(imm8_instr(proc_pkg::OP_LBI, 3, 'h20 + k),
                         taken ? 16'(16'h10 + k) : 16'(16'h20 + k));
        end
        run_program(1'b0);
    endtask

    task automatic jump_test();
        int jal_pc;
        new_program(16'h0040);
        jal_pc = 2 * prog.size();
        // byte 2 calls byte 10
        prog.push_back(jump_instr(proc_pkg::OP_JAL, 6));
        // byte 4 skips the store at byte 6
        prog.push_back(jump_instr(proc_pkg::OP_J, 2));
        prog.push_back(imm5_instr(proc_pkg::OP_ST, 6, 7, 2));
        prog.push_back(jump_instr(proc_pkg::OP_HALT, 0));
        // subroutine
        prog.push_back(imm5_instr(proc_pkg::OP_ST, 6, 7, 0));
        expect_store(base_addr, 16'(jal_pc + 2));
        prog.push_back(imm8_instr(proc_pkg::OP_JR, 7, 0));
        run_program(1'b0);
    endtask

    task automatic halt_test();
        new_program(16'h0040);
        op_and_store(imm8_instr(proc_pkg::OP_LBI, 3, 'h5a), 16'h005a);
        // opcode 00010 is outside the subset
        prog.push_back({5'b00010, 11'd0});
        prog.push_back(imm5_instr(proc_pkg::OP_ST, 6, 3, 2));
        run_program(1'b1);
        // halted core ignores the loader and start
        loader_write(1'b0, 3, jump_instr(proc_pkg::OP_NOP, 0));
        pulse_start();
        repeat (10) @(negedge i_clk);
        assert (o_halted && o_err) else begin
            $display("core left the halted error state after a loader write");
            errors++;
        end
        new_program(16'h0040);
        op_and_store(imm8_instr(proc_pkg::OP_LBI, 3, 'h33), 16'h0033);
        run_program(1'b0);
    endtask

    //////////////////////////////
    // run control
    //////////////////////////////
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a test never finished", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'hd44c));
        i_arst_n     = 1'b0;
        i_start      = 1'b0;
        i_load_we    = 1'b0;
        i_load_dmem  = 1'b0;
        i_load_addr  = '0;
        i_load_data  = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        e0 = errors;
        arith_test();
        report("arith", e0);
        e0 = errors;
        compare_test();
        report("compare", e0);
        e0 = errors;
        load_store_test();
        report("load_store", e0);
        e0 = errors;
        branch_test();
        report("branch", e0);
        e0 = errors;
        jump_test();
        report("jump", e0);
        e0 = errors;
        halt_test();
        report("halt", e0);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
